/* common/plic_params.svh */
// PLIC build parameters
// source and target counts, field widths and the APB register map
`ifndef PLIC_PARAMS_SVH
`define PLIC_PARAMS_SVH

// --------------------------------------------------
// sizes
// --------------------------------------------------
// ids 1..7 are sources, id 0 means no interrupt
`define PLIC_NUM_SOURCES 7
`define PLIC_NUM_TARGETS 2
`define PLIC_ID_W        3
`define PLIC_PRIO_W      3
`define PLIC_ADDR_W      32
`define PLIC_DATA_W      32

// --------------------------------------------------
// register map
// --------------------------------------------------
// one priority word per id, base + 4 * id
`define PLIC_PRIO_BASE   32'h0000_0000
// read only, bit n is pending flag of source n
`define PLIC_PEND_ADDR   32'h0000_0080
// one enable word per target, base + 4 * target
`define PLIC_ENABLE_BASE 32'h0000_0100
// 8 bytes per target: threshold at +0, claim/complete at +4
`define PLIC_TARGET_BASE 32'h0000_0200

`endif

/* common/plic_pkg.sv */
// PLIC shared types
// id, priority and bus word types plus the gateway and register decode enums
`include "plic_params.svh"

package plic_pkg;

    // source id, 0 is reserved for no interrupt
    typedef logic [`PLIC_ID_W-1:0]   plic_id_t;
    // priority 0 never interrupts
    typedef logic [`PLIC_PRIO_W-1:0] plic_prio_t;
    typedef logic [`PLIC_DATA_W-1:0] plic_data_t;

    // gateway life cycle of one request
    typedef enum logic [1:0] {
        GW_IDLE,
        GW_PENDING,
        GW_CLAIMED
    } gateway_state_e;

    // region hit by an APB address
    typedef enum logic [2:0] {
        REG_PRIORITY,
        REG_PENDING,
        REG_ENABLE,
        REG_THRESHOLD,
        REG_CLAIM,
        REG_NONE
    } reg_region_e;

endpackage

/* rtl/plic_gateway.sv */
// PLIC gateway
// turns a level request into a pending flag and masks the source
// from claim until complete
module plic_gateway import plic_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic irq_source_i,
    input  logic claim_i,
    input  logic complete_i,
    output logic irq_pending_o
);

    gateway_state_e state_q;

    // idle -> pending on level, pending -> claimed on claim,
    // claimed -> idle on complete
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= GW_IDLE;
        end else begin
            case (state_q)
                GW_IDLE: begin
                    if (irq_source_i) begin
                        state_q <= GW_PENDING;
                    end
                end
                GW_PENDING: begin
                    if (claim_i) begin
                        state_q <= GW_CLAIMED;
                    end
                end
                GW_CLAIMED: begin
                    // source stays masked until its owner completes it
                    if (complete_i) begin
                        state_q <= GW_IDLE;
                    end
                end
                default: state_q <= GW_IDLE;
            endcase
        end
    end

    // only a pending request reaches the target slices
    assign irq_pending_o = (state_q == GW_PENDING);

    // the tracker only claims ids that a slice picked from the pending set
    a_claim_when_pending: assert property (
        @(posedge clk_i) disable iff (rst_i) claim_i |-> state_q == GW_PENDING
    );

endmodule

/* rtl/plic_target_slice.sv */
// PLIC target slice
// picks the highest priority pending and enabled source for one target,
// lowest id on a tie, and raises eip when it beats the threshold
`include "plic_params.svh"

module plic_target_slice import plic_pkg::*; (
    input  logic       [`PLIC_NUM_SOURCES:1] pending_i,
    input  plic_prio_t [`PLIC_NUM_SOURCES:1] priority_i,
    input  logic       [`PLIC_NUM_SOURCES:1] enable_i,
    input  plic_prio_t                       threshold_i,
    output logic                             eip_o,
    output plic_id_t                         best_id_o
);

    // tree is padded up to a power of two
    localparam int LEAVES = 1 << $clog2(`PLIC_NUM_SOURCES);

    logic       [LEAVES-1:0] leaf_valid;
    plic_prio_t [LEAVES-1:0] leaf_prio;

    // --------------------------------------------------
    // leaves, leaf i is source i + 1
    // --------------------------------------------------
    for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
        if (i < `PLIC_NUM_SOURCES) begin : g_src
            // priority 0 never takes part
            assign leaf_valid[i] = pending_i[i+1] & enable_i[i+1]
                                 & (priority_i[i+1] != '0);
            assign leaf_prio[i]  = priority_i[i+1];
        end else begin : g_pad
            assign leaf_valid[i] = 1'b0;
            assign leaf_prio[i]  = '0;
        end
    end

    // --------------------------------------------------
    // compare tree, heap order, node k has children 2k and 2k+1
    // --------------------------------------------------
    always_comb begin : tree
        plic_prio_t node_prio [1:2*LEAVES-1];
        plic_id_t   node_id   [1:2*LEAVES-1];

        // non-candidates carry priority 0 and id 0
        for (int i = 0; i < LEAVES; i++) begin
            node_prio[LEAVES+i] = leaf_valid[i] ? leaf_prio[i] : '0;
            node_id[LEAVES+i]   = leaf_valid[i] ? plic_id_t'(i + 1) : '0;
        end

        // left child holds the lower ids, so it keeps a tie
        for (int k = LEAVES - 1; k >= 1; k--) begin
            if (node_prio[2*k+1] > node_prio[2*k]) begin
                node_prio[k] = node_prio[2*k+1];
                node_id[k]   = node_id[2*k+1];
            end else begin
                node_prio[k] = node_prio[2*k];
                node_id[k]   = node_id[2*k];
            end
        end

        best_id_o = node_id[1];
        // strictly greater, threshold equal to the winner masks it
        eip_o     = node_prio[1] > threshold_i;
    end

endmodule

/* rtl/plic_claim_complete_tracker.sv */
// PLIC claim/complete tracker
// records the owning target of each claimed source and forwards
// claim and complete pulses to the gateways one-hot
`include "plic_params.svh"

module plic_claim_complete_tracker import plic_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  plic_id_t [`PLIC_NUM_TARGETS-1:0]    best_id_i,
    input  logic     [`PLIC_NUM_TARGETS-1:0]    claim_i,
    input  logic     [`PLIC_NUM_TARGETS-1:0]    complete_i,
    input  plic_id_t [`PLIC_NUM_TARGETS-1:0]    complete_id_i,
    output logic     [`PLIC_NUM_SOURCES:1]      gw_claim_o,
    output logic     [`PLIC_NUM_SOURCES:1]      gw_complete_o
);

    localparam int TGT_W = $clog2(`PLIC_NUM_TARGETS);

    // owner and valid flag per source
    logic [`PLIC_NUM_SOURCES:1][TGT_W-1:0] owner_q;
    logic [`PLIC_NUM_SOURCES:1]            valid_q;
    logic [`PLIC_NUM_SOURCES:1][TGT_W-1:0] claim_tgt;

    // --------------------------------------------------
    // claim routing
    // --------------------------------------------------
    always_comb begin
        gw_claim_o = '0;
        claim_tgt  = '0;
        // walk downwards so the lower target overwrites on a collision
        for (int t = `PLIC_NUM_TARGETS - 1; t >= 0; t--) begin
            // id 0 means nothing to claim
            if (claim_i[t] && best_id_i[t] != '0) begin
                gw_claim_o[best_id_i[t]] = 1'b1;
                claim_tgt[best_id_i[t]]  = TGT_W'(t);
            end
        end
    end

    // --------------------------------------------------
    // complete filter, only the recorded owner gets through
    // --------------------------------------------------
    always_comb begin
        gw_complete_o = '0;
        for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
            if (complete_i[t] && complete_id_i[t] != '0 &&
                valid_q[complete_id_i[t]] &&
                owner_q[complete_id_i[t]] == TGT_W'(t)) begin
                gw_complete_o[complete_id_i[t]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            owner_q <= '0;
        end else begin
            for (int s = 1; s <= `PLIC_NUM_SOURCES; s++) begin
                if (gw_claim_o[s]) begin
                    valid_q[s] <= 1'b1;
                    owner_q[s] <= claim_tgt[s];
                end else if (gw_complete_o[s]) begin
                    // record freed, gateway re-arms at the same edge
                    valid_q[s] <= 1'b0;
                end
            end
        end
    end

    // the bus issues one access per cycle, so claims never fan out
    a_claim_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot0(gw_claim_o)
    );

endmodule

/* rtl/plic_apb_regs.sv */
// PLIC APB register block
// priority, enable and threshold storage, pending readback and
// claim/complete pulses, every access finishes in its access cycle
`include "plic_params.svh"

module plic_apb_regs import plic_pkg::*; (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic       [`PLIC_ADDR_W-1:0]         paddr_i,
    input  plic_data_t                            pwdata_i,
    output plic_data_t                            prdata_o,
    output logic                                  pslverr_o,
    input  logic       [`PLIC_NUM_SOURCES:1]      pending_i,
    input  plic_id_t   [`PLIC_NUM_TARGETS-1:0]    best_id_i,
    output plic_prio_t [`PLIC_NUM_SOURCES:1]      priority_o,
    output logic       [`PLIC_NUM_TARGETS-1:0][`PLIC_NUM_SOURCES:1] enable_o,
    output plic_prio_t [`PLIC_NUM_TARGETS-1:0]    threshold_o,
    output logic       [`PLIC_NUM_TARGETS-1:0]    claim_o,
    output logic       [`PLIC_NUM_TARGETS-1:0]    complete_o,
    output plic_id_t   [`PLIC_NUM_TARGETS-1:0]    complete_id_o
);

    localparam int TGT_W = $clog2(`PLIC_NUM_TARGETS);

    plic_prio_t [`PLIC_NUM_SOURCES:1]                        prio_q;
    logic       [`PLIC_NUM_TARGETS-1:0][`PLIC_NUM_SOURCES:1] en_q;
    plic_prio_t [`PLIC_NUM_TARGETS-1:0]                      thresh_q;

    logic                    access;
    logic                    wr_en;
    logic                    rd_en;
    logic [`PLIC_ADDR_W-1:0] prio_off;
    logic [`PLIC_ADDR_W-1:0] en_off;
    logic [`PLIC_ADDR_W-1:0] tgt_off;
    plic_id_t                prio_idx;
    logic [TGT_W-1:0]        en_tgt;
    logic [TGT_W-1:0]        tgt_sel;
    reg_region_e             region;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;
    assign rd_en  = access & ~pwrite_i;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    // offsets below a base wrap to large values and miss the range check
    assign prio_off = paddr_i - `PLIC_PRIO_BASE;
    assign en_off   = paddr_i - `PLIC_ENABLE_BASE;
    assign tgt_off  = paddr_i - `PLIC_TARGET_BASE;
    assign prio_idx = prio_off[2 +: `PLIC_ID_W];
    assign en_tgt   = en_off[2 +: TGT_W];
    assign tgt_sel  = tgt_off[3 +: TGT_W];

    always_comb begin
        region = REG_NONE;
        // unaligned addresses stay unmapped
        if (paddr_i[1:0] == 2'b00) begin
            if (prio_off < 4 * (`PLIC_NUM_SOURCES + 1)) begin
                region = REG_PRIORITY;
            end else if (paddr_i == `PLIC_PEND_ADDR) begin
                region = REG_PENDING;
            end else if (en_off < 4 * `PLIC_NUM_TARGETS) begin
                region = REG_ENABLE;
            end else if (tgt_off < 8 * `PLIC_NUM_TARGETS) begin
                // word at +4 is claim/complete
                region = tgt_off[2] ? REG_CLAIM : REG_THRESHOLD;
            end
        end
    end

    // --------------------------------------------------
    // register writes, at the edge ending the access cycle
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_q   <= '0;
            en_q     <= '0;
            thresh_q <= '0;
        end else if (wr_en) begin
            case (region)
                REG_PRIORITY: begin
                    // id 0 has no priority register
                    if (prio_idx != '0) begin
                        prio_q[prio_idx] <= pwdata_i[`PLIC_PRIO_W-1:0];
                    end
                end
                // bit 0 is id 0 and is never stored
                REG_ENABLE:    en_q[en_tgt]      <= pwdata_i[`PLIC_NUM_SOURCES:1];
                REG_THRESHOLD: thresh_q[tgt_sel] <= pwdata_i[`PLIC_PRIO_W-1:0];
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // read mux, fields zero extended
    // --------------------------------------------------
    always_comb begin
        prdata_o = '0;
        case (region)
            REG_PRIORITY: begin
                if (prio_idx != '0) begin
                    prdata_o[`PLIC_PRIO_W-1:0] = prio_q[prio_idx];
                end
            end
            REG_PENDING:   prdata_o[`PLIC_NUM_SOURCES:1] = pending_i;
            REG_ENABLE:    prdata_o[`PLIC_NUM_SOURCES:1] = en_q[en_tgt];
            REG_THRESHOLD: prdata_o[`PLIC_PRIO_W-1:0]    = thresh_q[tgt_sel];
            // claim returns the current winner, 0 when nothing is pending
            REG_CLAIM:     prdata_o[`PLIC_ID_W-1:0]      = best_id_i[tgt_sel];
            default: ;
        endcase
    end

    // unmapped access, or a write to the read-only pending word
    assign pslverr_o = access &
                       ((region == REG_NONE) | (pwrite_i & (region == REG_PENDING)));

    // claim on read, complete on write of the claim word
    always_comb begin
        for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
            claim_o[t]       = rd_en & (region == REG_CLAIM) & (tgt_sel == TGT_W'(t));
            complete_o[t]    = wr_en & (region == REG_CLAIM) & (tgt_sel == TGT_W'(t));
            complete_id_o[t] = pwdata_i[`PLIC_ID_W-1:0];
        end
    end

    assign priority_o  = prio_q;
    assign enable_o    = en_q;
    assign threshold_o = thresh_q;

    // access phase is always framed by a select from the master
    a_penable_with_psel: assert property (
        @(posedge clk_i) disable iff (rst_i) penable_i |-> psel_i
    );

endmodule

/* rtl/plic.sv */
// PLIC top level
// gateways per source, one slice per target, claim/complete tracker
// and the APB register block
`include "plic_params.svh"

module plic import plic_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [`PLIC_NUM_SOURCES:1]    irq_sources_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`PLIC_ADDR_W-1:0]       paddr_i,
    input  plic_data_t                    pwdata_i,
    output plic_data_t                    prdata_o,
    output logic                          pslverr_o,
    output logic [`PLIC_NUM_TARGETS-1:0]  eip_targets_o
);

    // gateway side, indexed by source id
    logic       [`PLIC_NUM_SOURCES:1]                        pending;
    logic       [`PLIC_NUM_SOURCES:1]                        gw_claim;
    logic       [`PLIC_NUM_SOURCES:1]                        gw_complete;
    plic_prio_t [`PLIC_NUM_SOURCES:1]                        prio;
    // target side
    logic       [`PLIC_NUM_TARGETS-1:0][`PLIC_NUM_SOURCES:1] enable;
    plic_prio_t [`PLIC_NUM_TARGETS-1:0]                      threshold;
    plic_id_t   [`PLIC_NUM_TARGETS-1:0]                      best_id;
    logic       [`PLIC_NUM_TARGETS-1:0]                      claim;
    logic       [`PLIC_NUM_TARGETS-1:0]                      complete;
    plic_id_t   [`PLIC_NUM_TARGETS-1:0]                      complete_id;

    // --------------------------------------------------
    // gateways, ids start at 1
    // --------------------------------------------------
    for (genvar s = 1; s <= `PLIC_NUM_SOURCES; s++) begin : g_gateway
        plic_gateway u_gateway (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .irq_source_i  (irq_sources_i[s]),
            .claim_i       (gw_claim[s]),
            .complete_i    (gw_complete[s]),
            .irq_pending_o (pending[s])
        );
    end

    // --------------------------------------------------
    // target slices
    // --------------------------------------------------
    for (genvar t = 0; t < `PLIC_NUM_TARGETS; t++) begin : g_slice
        plic_target_slice u_slice (
            .pending_i   (pending),
            .priority_i  (prio),
            .enable_i    (enable[t]),
            .threshold_i (threshold[t]),
            .eip_o       (eip_targets_o[t]),
            .best_id_o   (best_id[t])
        );
    end

    plic_claim_complete_tracker u_tracker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .best_id_i     (best_id),
        .claim_i       (claim),
        .complete_i    (complete),
        .complete_id_i (complete_id),
        .gw_claim_o    (gw_claim),
        .gw_complete_o (gw_complete)
    );

    plic_apb_regs u_regs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pslverr_o     (pslverr_o),
        .pending_i     (pending),
        .best_id_i     (best_id),
        .priority_o    (prio),
        .enable_o      (enable),
        .threshold_o   (threshold),
        .claim_o       (claim),
        .complete_o    (complete),
        .complete_id_o (complete_id)
    );

endmodule

/* tb/tb_plic.sv */
// PLIC testbench
// table of APB, source and eip steps applied in a loop against the plic top
`include "plic_params.svh"

module tb_plic import plic_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;

    typedef logic [`PLIC_ADDR_W-1:0]      addr_t;
    typedef logic [`PLIC_NUM_TARGETS-1:0] eip_t;

    // kind of one table step
    typedef enum logic [1:0] {
        STEP_SOURCES,
        STEP_WRITE,
        STEP_READ,
        STEP_EIP
    } step_kind_e;

    // data is the source vector, the write data or the expected read data
    typedef struct packed {
        step_kind_e kind;
        addr_t      addr;
        plic_data_t data;
        logic       err;
        eip_t       eip;
    } step_t;

    logic                         clk_i;
    logic                         rst_i;
    logic [`PLIC_NUM_SOURCES:1]   irq_sources_i;
    logic                         psel_i;
    logic                         penable_i;
    logic                         pwrite_i;
    addr_t                        paddr_i;
    plic_data_t                   pwdata_i;
    plic_data_t                   prdata_o;
    logic                         pslverr_o;
    eip_t                         eip_targets_o;

    step_t steps[$];
    int    cycle_limit;
    int    cycle_count;

    plic uut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .irq_sources_i (irq_sources_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pslverr_o     (pslverr_o),
        .eip_targets_o (eip_targets_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // register map addresses
    // --------------------------------------------------
    function automatic addr_t prio_addr(input int id);
        return `PLIC_PRIO_BASE + addr_t'(4 * id);
    endfunction

    function automatic addr_t enable_addr(input int tgt);
        return `PLIC_ENABLE_BASE + addr_t'(4 * tgt);
    endfunction

    function automatic addr_t thresh_addr(input int tgt);
        return `PLIC_TARGET_BASE + addr_t'(8 * tgt);
    endfunction

    function automatic addr_t claim_addr(input int tgt);
        return `PLIC_TARGET_BASE + addr_t'(8 * tgt + 4);
    endfunction

    // claim word sits at +4 inside each 8 byte target block
    function automatic logic is_claim_addr(input addr_t addr);
        addr_t off;
        off = addr - `PLIC_TARGET_BASE;
        return (off < addr_t'(8 * `PLIC_NUM_TARGETS)) && (off[2:0] == 3'b100);
    endfunction

    // --------------------------------------------------
    // compare tasks, stop at the first mismatch
    // --------------------------------------------------
    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input string name, input plic_data_t got, input plic_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_id(input string name, input plic_id_t got, input plic_id_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_eip(input string name, input eip_t got, input eip_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // table builders
    // --------------------------------------------------
    // bit n of bits drives source n
    task automatic src_step(input plic_data_t bits);
        steps.push_back('{STEP_SOURCES, '0, bits, 1'b0, '0});
    endtask

    task automatic wr_step(input addr_t addr, input plic_data_t data, input logic err);
        steps.push_back('{STEP_WRITE, addr, data, err, '0});
    endtask

    task automatic rd_step(input addr_t addr, input plic_data_t exp, input logic err);
        steps.push_back('{STEP_READ, addr, exp, err, '0});
    endtask

    task automatic eip_step(input eip_t exp);
        steps.push_back('{STEP_EIP, '0, '0, 1'b0, exp});
    endtask

    task automatic build_steps();
        // reset values
        rd_step(prio_addr(1), 32'h0, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h0, 1'b0);
        rd_step(enable_addr(1), 32'h0, 1'b0);
        rd_step(thresh_addr(0), 32'h0, 1'b0);
        eip_step(2'b00);
        // readback truncated to field widths, id 0 and enable bit 0 read 0
        wr_step(prio_addr(1), 32'hFFFF_FFFD, 1'b0);
        rd_step(prio_addr(1), 32'h5, 1'b0);
        wr_step(prio_addr(0), 32'h7, 1'b0);
        rd_step(prio_addr(0), 32'h0, 1'b0);
        wr_step(enable_addr(0), 32'hFFFF_FFFF, 1'b0);
        rd_step(enable_addr(0), 32'hFE, 1'b0);
        wr_step(thresh_addr(1), 32'h1A, 1'b0);
        rd_step(thresh_addr(1), 32'h2, 1'b0);
        // priorities 1:2 2:5 3:5 4:1 5:0 6:7 7:3
        wr_step(prio_addr(1), 32'h2, 1'b0);
        wr_step(prio_addr(2), 32'h5, 1'b0);
        wr_step(prio_addr(3), 32'h5, 1'b0);
        wr_step(prio_addr(4), 32'h1, 1'b0);
        wr_step(prio_addr(6), 32'h7, 1'b0);
        wr_step(prio_addr(7), 32'h3, 1'b0);
        // target 0 sees sources 1..5, target 1 sees 3, 6 and 7
        wr_step(enable_addr(0), 32'h3E, 1'b0);
        wr_step(enable_addr(1), 32'hC8, 1'b0);
        wr_step(thresh_addr(1), 32'h0, 1'b0);
        rd_step(enable_addr(1), 32'hC8, 1'b0);
        // --------------------------------------------------
        // target 0 alone, sources 1 and 4
        // --------------------------------------------------
        src_step(32'h12);
        rd_step(`PLIC_PEND_ADDR, 32'h12, 1'b0);
        eip_step(2'b01);
        // threshold equal to the winner masks eip
        wr_step(thresh_addr(0), 32'h2, 1'b0);
        eip_step(2'b00);
        wr_step(thresh_addr(0), 32'h1, 1'b0);
        eip_step(2'b01);
        rd_step(claim_addr(0), 32'h1, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h10, 1'b0);
        eip_step(2'b00);
        rd_step(claim_addr(0), 32'h4, 1'b0);
        rd_step(claim_addr(0), 32'h0, 1'b0);
        // complete from the wrong target is dropped
        wr_step(claim_addr(1), 32'h1, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h0, 1'b0);
        // owner complete re-arms, source 1 still high
        wr_step(claim_addr(0), 32'h1, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h02, 1'b0);
        eip_step(2'b01);
        src_step(32'h0);
        wr_step(claim_addr(0), 32'h4, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h02, 1'b0);
        rd_step(claim_addr(0), 32'h1, 1'b0);
        wr_step(claim_addr(0), 32'h1, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h0, 1'b0);
        // --------------------------------------------------
        // both targets, sources 2 3 6 7
        // --------------------------------------------------
        src_step(32'hCC);
        rd_step(`PLIC_PEND_ADDR, 32'hCC, 1'b0);
        eip_step(2'b11);
        rd_step(claim_addr(1), 32'h6, 1'b0);
        rd_step(claim_addr(1), 32'h3, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h84, 1'b0);
        wr_step(thresh_addr(1), 32'h3, 1'b0);
        eip_step(2'b01);
        wr_step(claim_addr(0), 32'h3, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h84, 1'b0);
        wr_step(claim_addr(1), 32'h3, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h8C, 1'b0);
        // tie at priority 5, lower id first
        rd_step(claim_addr(0), 32'h2, 1'b0);
        rd_step(claim_addr(0), 32'h3, 1'b0);
        rd_step(claim_addr(1), 32'h7, 1'b0);
        rd_step(claim_addr(0), 32'h0, 1'b0);
        eip_step(2'b00);
        src_step(32'h0);
        wr_step(claim_addr(1), 32'h6, 1'b0);
        wr_step(claim_addr(0), 32'h2, 1'b0);
        wr_step(claim_addr(0), 32'h3, 1'b0);
        wr_step(claim_addr(1), 32'h7, 1'b0);
        rd_step(`PLIC_PEND_ADDR, 32'h0, 1'b0);
        // priority 0 pends but never wins
        src_step(32'h20);
        rd_step(`PLIC_PEND_ADDR, 32'h20, 1'b0);
        eip_step(2'b00);
        rd_step(claim_addr(0), 32'h0, 1'b0);
        // bus errors, pending word stays untouched
        rd_step(32'h300, 32'h0, 1'b1);
        wr_step(`PLIC_PEND_ADDR, 32'hFF, 1'b1);
        rd_step(32'h202, 32'h0, 1'b1);
        rd_step(`PLIC_PEND_ADDR, 32'h20, 1'b0);
    endtask

    // --------------------------------------------------
    // drivers
    // --------------------------------------------------
    // setup cycle, access cycle, outputs sampled mid access cycle
    task automatic apb_access(input logic write, input addr_t addr, input plic_data_t wdata,
                              output plic_data_t rdata, output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apply_step(input step_t s);
        plic_data_t rdata;
        logic       rerr;
        case (s.kind)
            STEP_SOURCES: begin
                @(negedge clk_i);
                irq_sources_i = s.data[`PLIC_NUM_SOURCES:1];
                // gateway needs one edge, two gives margin
                repeat (2) @(negedge clk_i);
            end
            STEP_WRITE: begin
                apb_access(1'b1, s.addr, s.data, rdata, rerr);
                check_err("pslverr_o", rerr, s.err);
            end
            STEP_READ: begin
                apb_access(1'b0, s.addr, '0, rdata, rerr);
                check_err("pslverr_o", rerr, s.err);
                if (is_claim_addr(s.addr)) begin
                    check_id("claim id", rdata[`PLIC_ID_W-1:0], s.data[`PLIC_ID_W-1:0]);
                end
                check_data("prdata_o", rdata, s.data);
            end
            default: begin
                @(negedge clk_i);
                check_eip("eip_targets_o", eip_targets_o, s.eip);
            end
        endcase
    endtask

    initial begin : main
        rst_i         = 1'b1;
        irq_sources_i = '0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        build_steps();
        // no step takes more than 4 cycles
        cycle_limit = 4 * steps.size() + 50;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Testbench passed");
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count <= cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

endmodule

/* src.f */
+incdir+common
common/plic_pkg.sv
rtl/plic_gateway.sv
rtl/plic_target_slice.sv
rtl/plic_claim_complete_tracker.sv
rtl/plic_apb_regs.sv
rtl/plic.sv
tb/tb_plic.sv

/* Makefile */
# Verilator flow for the PLIC testbench

TOP = tb_plic

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timescale 1ns/100ps -f src.f --top-module $(TOP) -o V$(TOP)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
